// ==== verilog/cp_bond_pkg.sv ====
// lane bonding control plane types

package cp_bond_pkg;

   // ------------------------------------------------------------
   // counter widths
   // ------------------------------------------------------------

   // compensation counter width
   localparam int CNT_W = 8;

   // compensation count or live counter value
   typedef logic [CNT_W-1:0] comp_cnt_t;

   // ------------------------------------------------------------
   // lane roles
   // ------------------------------------------------------------

   // role code of one lane
   typedef logic [1:0] compin_sel_t;

   // enabled by the bonding controller
   localparam compin_sel_t SEL_MASTER      = 2'd0;
   // enabled by the tap from the lane below
   localparam compin_sel_t SEL_SLAVE_ABOVE = 2'd1;
   // enabled by the tap from the lane above
   localparam compin_sel_t SEL_SLAVE_BELOW = 2'd2;
   // code 3 is not named and falls back to master

   // static per-lane configuration, 10 bits
   typedef struct packed {
      compin_sel_t sel;
      comp_cnt_t   comp_cnt;
   } lane_cfg_t;

   // ------------------------------------------------------------
   // controller FSM
   // ------------------------------------------------------------

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_CLEAR = 2'd1,
      ST_COUNT = 2'd2,
      ST_DONE  = 2'd3
   } bond_state_t;

endpackage

// ==== verilog/cp_comp_cntr.sv ====
// lane compensation counter

`timescale 1ns/10ps

module cp_comp_cntr
(
   input  logic                  clk,
   input  logic                  rst_n,
   // soft clear from the bonding controller
   input  logic                  srst_n,
   // data valid of this lane
   input  logic                  data_enable,
   // enable sources, one per role
   input  logic                  master_in_en,
   input  logic                  us_tap_en,
   input  logic                  ds_tap_en,
   // static role and count
   input  cp_bond_pkg::lane_cfg_t cfg,
   // high while enabled at the programmed count
   output logic                  comp_cnt_match,
   // selected enable, forwarded to the neighbours
   output logic                  compin_sel
);

   // running count
   cp_bond_pkg::comp_cnt_t cnt;
   // enable picked by role
   logic                   cnt_en;
   // count has reached its target
   logic                   at_target;

   // ------------------------------------------------------------
   // enable source select
   // ------------------------------------------------------------

   always_comb
   begin
      case (cfg.sel)
         cp_bond_pkg::SEL_MASTER:
         begin
            cnt_en = master_in_en;
         end
         cp_bond_pkg::SEL_SLAVE_ABOVE:
         begin
            cnt_en = us_tap_en;
         end
         cp_bond_pkg::SEL_SLAVE_BELOW:
         begin
            cnt_en = ds_tap_en;
         end
         default:
         begin
            // unused code acts as master
            cnt_en = master_in_en;
         end
      endcase
   end

   assign compin_sel = cnt_en;

   // ------------------------------------------------------------
   // count and match
   // ------------------------------------------------------------

   assign at_target = (cnt == cfg.comp_cnt);

   // a zero count matches on the first enabled cycle
   assign comp_cnt_match = cnt_en & at_target;

   // saturates at the target, stalls while data_enable is low
   always_ff @(posedge clk)
   begin
      if (!rst_n || !srst_n)
      begin
         cnt <= '0;
      end
      else if (cnt_en && data_enable && !at_target)
      begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

// ==== verilog/cp_tap_chain.sv ====
// lane enable tap chain

`timescale 1ns/10ps

module cp_tap_chain
#(
   parameter int NUM_LANES = 4
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   // soft clear from the bonding controller
   input  logic                 srst_n,
   // selected enable of every lane
   input  logic [NUM_LANES-1:0] compin_sel,
   // enable coming up from lane i-1
   output logic [NUM_LANES-1:0] us_tap_en,
   // enable coming down from lane i+1
   output logic [NUM_LANES-1:0] ds_tap_en
);

   // one forwarding flop per lane
   logic [NUM_LANES-1:0] tap_q;

   // ------------------------------------------------------------
   // forwarding registers
   // ------------------------------------------------------------

   // every hop is registered so no loop closes through the lanes
   always_ff @(posedge clk)
   begin
      if (!rst_n || !srst_n)
      begin
         tap_q <= '0;
      end
      else
      begin
         tap_q <= compin_sel;
      end
   end

   // ------------------------------------------------------------
   // neighbour fan-out
   // ------------------------------------------------------------

   genvar i;
   generate
      for (i = 0; i < NUM_LANES; i++)
      begin : g_hop
         // upward path
         if (i == 0)
         begin : g_us_end
            // bottom lane has nothing below
            assign us_tap_en[i] = 1'b0;
         end
         else
         begin : g_us
            assign us_tap_en[i] = tap_q[i-1];
         end

         // downward path
         if (i == NUM_LANES - 1)
         begin : g_ds_end
            // top lane has nothing above
            assign ds_tap_en[i] = 1'b0;
         end
         else
         begin : g_ds
            assign ds_tap_en[i] = tap_q[i+1];
         end
      end
   endgenerate

endmodule

// ==== verilog/cp_bond_ctrl.sv ====
// bonding run controller

`timescale 1ns/10ps

module cp_bond_ctrl
#(
   parameter int NUM_LANES = 4
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   // one-cycle request to start a run
   input  logic                 bond_start,
   // match of every lane counter
   input  logic [NUM_LANES-1:0] lane_match,
   // soft clear to counters and taps, active low
   output logic                 srst_n,
   // enable for the master lane
   output logic                 master_in_en,
   // all lanes matched
   output logic                 bond_done,
   // run in progress
   output logic                 bond_busy
);

   cp_bond_pkg::bond_state_t state;
   cp_bond_pkg::bond_state_t state_nxt;

   // every lane at its count in the same cycle
   logic all_match;

   assign all_match = &lane_match;

   // ------------------------------------------------------------
   // state register
   // ------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= cp_bond_pkg::ST_IDLE;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // ------------------------------------------------------------
   // next state
   // ------------------------------------------------------------

   always_comb
   begin
      state_nxt = state;
      case (state)
         cp_bond_pkg::ST_IDLE:
         begin
            if (bond_start)
            begin
               state_nxt = cp_bond_pkg::ST_CLEAR;
            end
         end
         cp_bond_pkg::ST_CLEAR:
         begin
            // single clear cycle, start is ignored here
            state_nxt = cp_bond_pkg::ST_COUNT;
         end
         cp_bond_pkg::ST_COUNT:
         begin
            if (all_match)
            begin
               state_nxt = cp_bond_pkg::ST_DONE;
            end
         end
         cp_bond_pkg::ST_DONE:
         begin
            // restart clears and reruns
            if (bond_start)
            begin
               state_nxt = cp_bond_pkg::ST_CLEAR;
            end
         end
         default:
         begin
            state_nxt = cp_bond_pkg::ST_IDLE;
         end
      endcase
   end

   // ------------------------------------------------------------
   // outputs, decoded from state only
   // ------------------------------------------------------------

   assign srst_n       = (state != cp_bond_pkg::ST_CLEAR);
   // held in done so the matches stay up
   assign master_in_en = (state == cp_bond_pkg::ST_COUNT) ||
                         (state == cp_bond_pkg::ST_DONE);
   assign bond_done    = (state == cp_bond_pkg::ST_DONE);
   assign bond_busy    = (state == cp_bond_pkg::ST_CLEAR) ||
                         (state == cp_bond_pkg::ST_COUNT);

endmodule

// ==== verilog/cp_bond_top.sv ====
// lane bonding control plane top

`timescale 1ns/10ps

module cp_bond_top
#(
   parameter int NUM_LANES = 4
)
(
   input  logic                                   clk,
   input  logic                                   rst_n,
   // one-cycle run request
   input  logic                                   bond_start,
   // per-lane data valid
   input  logic [NUM_LANES-1:0]                   data_enable,
   // per-lane role and compensation count
   input  cp_bond_pkg::lane_cfg_t [NUM_LANES-1:0] lane_cfg,
   // per-lane counter match
   output logic [NUM_LANES-1:0]                   lane_match,
   output logic                                   bond_done,
   output logic                                   bond_busy
);

   // ------------------------------------------------------------
   // internal wiring
   // ------------------------------------------------------------

   // controller to counters
   logic                 srst_n;
   logic                 master_in_en;

   // counters to tap chain
   logic [NUM_LANES-1:0] compin_sel;

   // tap chain back to counters
   logic [NUM_LANES-1:0] us_tap_en;
   logic [NUM_LANES-1:0] ds_tap_en;

   // ------------------------------------------------------------
   // lane counters
   // ------------------------------------------------------------

   genvar i;
   generate
      for (i = 0; i < NUM_LANES; i++)
      begin : g_lane
         cp_comp_cntr u_comp_cntr
         (
            .clk            (clk),
            .rst_n          (rst_n),
            .srst_n         (srst_n),
            .data_enable    (data_enable[i]),
            .master_in_en   (master_in_en),
            .us_tap_en      (us_tap_en[i]),
            .ds_tap_en      (ds_tap_en[i]),
            .cfg            (lane_cfg[i]),
            .comp_cnt_match (lane_match[i]),
            .compin_sel     (compin_sel[i])
         );
      end
   endgenerate

   // ------------------------------------------------------------
   // enable forwarding between lanes
   // ------------------------------------------------------------

   cp_tap_chain #(
      .NUM_LANES (NUM_LANES)
   ) u_tap_chain (
      .clk        (clk),
      .rst_n      (rst_n),
      .srst_n     (srst_n),
      .compin_sel (compin_sel),
      .us_tap_en  (us_tap_en),
      .ds_tap_en  (ds_tap_en)
   );

   // ------------------------------------------------------------
   // run sequencing
   // ------------------------------------------------------------

   cp_bond_ctrl #(
      .NUM_LANES (NUM_LANES)
   ) u_bond_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .bond_start   (bond_start),
      .lane_match   (lane_match),
      .srst_n       (srst_n),
      .master_in_en (master_in_en),
      .bond_done    (bond_done),
      .bond_busy    (bond_busy)
   );

endmodule

// ==== sim/cp_bond_sva.sv ====
// bonding controller assertions

`timescale 1ns/10ps

module cp_bond_sva
#(
   parameter int NUM_LANES = 4
)
(
   input logic                     clk,
   input logic                     rst_n,
   input logic                     bond_start,
   input cp_bond_pkg::bond_state_t state,
   input logic                     srst_n,
   input logic                     bond_done,
   input logic                     bond_busy,
   input logic [NUM_LANES-1:0]     lane_match
);

   // ------------------------------------------------------------
   // soft clear
   // ------------------------------------------------------------

   // low only after a start taken in idle or done
   a_srst_after_start: assert property (@(posedge clk) disable iff (!rst_n)
      !srst_n |-> ($past(bond_start) &&
                   (($past(state) == cp_bond_pkg::ST_IDLE) ||
                    ($past(state) == cp_bond_pkg::ST_DONE))))
      else $error("soft clear low without an accepted start");

   // single cycle pulse
   a_srst_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      !srst_n |=> srst_n)
      else $error("soft clear held low for more than one cycle");

   // ------------------------------------------------------------
   // status outputs
   // ------------------------------------------------------------

   // done is reached only from a busy run
   a_done_from_busy: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(bond_done) |-> $past(bond_busy))
      else $error("bond_done rose without a run in progress");

   // done entered only after every lane matched
   a_done_entry: assert property (@(posedge clk) disable iff (!rst_n)
      ((state == cp_bond_pkg::ST_DONE) && ($past(state) != cp_bond_pkg::ST_DONE))
      |-> $past(&lane_match))
      else $error("done state entered without all lanes matched");

endmodule

bind cp_bond_ctrl cp_bond_sva #(
   .NUM_LANES (NUM_LANES)
) u_bond_sva (
   .clk        (clk),
   .rst_n      (rst_n),
   .bond_start (bond_start),
   .state      (state),
   .srst_n     (srst_n),
   .bond_done  (bond_done),
   .bond_busy  (bond_busy),
   .lane_match (lane_match)
);

// ==== sim/cp_bond_tb.sv ====
// bonding control plane testbench

`timescale 1ns/10ps

module cp_bond_tb;

   localparam int NUM_LANES    = 4;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_RUNS     = 40;
   // generous per-run cycle allowance
   localparam int RUN_BUDGET   = 300;
   localparam int MAX_CYCLES   = RESET_CYCLES + NUM_RUNS * RUN_BUDGET;

   logic                                   clk;
   logic                                   rst_n;
   logic                                   bond_start;
   logic [NUM_LANES-1:0]                   data_enable;
   cp_bond_pkg::lane_cfg_t [NUM_LANES-1:0] lane_cfg;
   logic [NUM_LANES-1:0]                   lane_match;
   logic                                   bond_done;
   logic                                   bond_busy;

   // ------------------------------------------------------------
   // testbench state
   // ------------------------------------------------------------

   logic [31:0] rng_state = 32'h225784c9;
   // data_enable density, 0 is 25% up to 3 is 100%
   logic [1:0]  density   = 2'd3;
   string       test_name = "reset";
   int          cycle_count = 0;
   int          err_match = 0;
   int          err_done  = 0;
   int          err_busy  = 0;
   int          err_hold  = 0;
   // bond_done as seen at the last falling edge
   logic        done_q    = 1'b0;

   // reference model registers
   cp_bond_pkg::bond_state_t m_state = cp_bond_pkg::ST_IDLE;
   logic [NUM_LANES-1:0]     m_tap   = '0;
   cp_bond_pkg::comp_cnt_t   m_cnt [NUM_LANES];

   cp_bond_top #(
      .NUM_LANES (NUM_LANES)
   ) uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .bond_start  (bond_start),
      .data_enable (data_enable),
      .lane_cfg    (lane_cfg),
      .lane_match  (lane_match),
      .bond_done   (bond_done),
      .bond_busy   (bond_busy)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // xorshift32
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   // one clock, with fresh random data_enable bits
   task automatic step_cycle();
      logic [31:0] r;
      @(posedge clk);
      for (int i = 0; i < NUM_LANES; i++)
      begin
         r = next_rand();
         data_enable[i] <= (r[1:0] <= density);
      end
   endtask

   // master lane, roles pointing toward it, counts and density
   task automatic configure_run(input int run);
      logic [31:0] r;
      int          master;
      r = next_rand();
      master = r % NUM_LANES;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         r = next_rand();
         lane_cfg[i].comp_cnt <= {4'd0, r[3:0]};
         if (i == master)
         begin
            // one run uses the unnamed code 3
            lane_cfg[i].sel <= (run == 7) ? 2'd3 : cp_bond_pkg::SEL_MASTER;
         end
         else if (i < master)
         begin
            lane_cfg[i].sel <= cp_bond_pkg::SEL_SLAVE_BELOW;
         end
         else
         begin
            lane_cfg[i].sel <= cp_bond_pkg::SEL_SLAVE_ABOVE;
         end
      end
      r = next_rand();
      density = r[1:0];
   endtask

   // ------------------------------------------------------------
   // reference model and checks, on the falling edge
   // ------------------------------------------------------------

   always @(negedge clk)
   begin : model_check
      logic [NUM_LANES-1:0] en;
      logic [NUM_LANES-1:0] exp_match;
      logic                 exp_done;
      logic                 exp_busy;
      logic                 m_srst_n;
      logic                 m_master_en;
      m_master_en = (m_state == cp_bond_pkg::ST_COUNT) || (m_state == cp_bond_pkg::ST_DONE);
      m_srst_n    = (m_state != cp_bond_pkg::ST_CLEAR);
      for (int i = 0; i < NUM_LANES; i++)
      begin
         // enable by role, code 3 as master
         if (lane_cfg[i].sel == cp_bond_pkg::SEL_SLAVE_ABOVE)
            en[i] = (i > 0) ? m_tap[(i > 0) ? i - 1 : 0] : 1'b0;
         else if (lane_cfg[i].sel == cp_bond_pkg::SEL_SLAVE_BELOW)
            en[i] = (i < NUM_LANES - 1) ? m_tap[(i < NUM_LANES - 1) ? i + 1 : i] : 1'b0;
         else
            en[i] = m_master_en;
         exp_match[i] = en[i] && (m_cnt[i] == lane_cfg[i].comp_cnt);
      end
      exp_done = (m_state == cp_bond_pkg::ST_DONE);
      exp_busy = (m_state == cp_bond_pkg::ST_CLEAR) || (m_state == cp_bond_pkg::ST_COUNT);

      assert (lane_match === exp_match)
      else
      begin
         err_match++;
         $display("[ERROR] %s: lane_match expected %b, actual %b",
                  test_name, exp_match, lane_match);
      end
      assert (bond_done === exp_done)
      else
      begin
         err_done++;
         $display("[ERROR] %s: bond_done expected %b, actual %b", test_name, exp_done, bond_done);
      end
      assert (bond_busy === exp_busy)
      else
      begin
         err_busy++;
         $display("[ERROR] %s: bond_busy expected %b, actual %b", test_name, exp_busy, bond_busy);
      end
      // in done every lane must hold its match
      assert (!exp_done || (&lane_match))
      else
      begin
         err_hold++;
         $display("%s: a lane dropped its match while bonding was done", test_name);
      end
      done_q = bond_done;

      // advance the model by one clock
      if (!rst_n)
      begin
         m_state = cp_bond_pkg::ST_IDLE;
         m_tap   = '0;
         for (int i = 0; i < NUM_LANES; i++)
            m_cnt[i] = '0;
      end
      else
      begin
         for (int i = 0; i < NUM_LANES; i++)
         begin
            if (!m_srst_n)
            begin
               m_cnt[i] = '0;
               m_tap[i] = 1'b0;
            end
            else
            begin
               m_tap[i] = en[i];
               if (en[i] && data_enable[i] && (m_cnt[i] != lane_cfg[i].comp_cnt))
                  m_cnt[i] = m_cnt[i] + 1'b1;
            end
         end
         case (m_state)
            cp_bond_pkg::ST_IDLE:  if (bond_start) m_state = cp_bond_pkg::ST_CLEAR;
            cp_bond_pkg::ST_CLEAR: m_state = cp_bond_pkg::ST_COUNT;
            cp_bond_pkg::ST_COUNT: if (&exp_match) m_state = cp_bond_pkg::ST_DONE;
            default:               if (bond_start) m_state = cp_bond_pkg::ST_CLEAR;
         endcase
      end
   end

   // hang guard
   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("timeout: bonding runs did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------

   initial
   begin
      rst_n       = 1'b0;
      bond_start  = 1'b0;
      data_enable = '0;
      lane_cfg    = '0;
      for (int i = 0; i < NUM_LANES; i++)
         m_cnt[i] = '0;

      repeat (RESET_CYCLES) step_cycle();
      rst_n <= 1'b1;
      // idle after reset, nothing may move
      test_name = "idle";
      repeat (4) step_cycle();

      for (int run = 0; run < NUM_RUNS; run++)
      begin
         test_name = $sformatf("run%0d", run);
         step_cycle();
         bond_start <= 1'b1;
         step_cycle();
         // new roles and counts land while the counters clear
         configure_run(run);
         bond_start <= 1'b0;
         step_cycle();
         // stray start while busy on some runs
         if ((run % 3) == 1)
            bond_start <= 1'b1;
         step_cycle();
         bond_start <= 1'b0;
         while (!done_q)
            step_cycle();
         repeat (5) step_cycle();
      end

      $display("errors: lane_match %0d, bond_done %0d, bond_busy %0d, held match %0d",
               err_match, err_done, err_busy, err_hold);
      if ((err_match + err_done + err_busy + err_hold) == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== verilog.f ====
verilog/cp_bond_pkg.sv
verilog/cp_comp_cntr.sv
verilog/cp_tap_chain.sv
verilog/cp_bond_ctrl.sv
verilog/cp_bond_top.sv
sim/cp_bond_sva.sv
sim/cp_bond_tb.sv

// ==== Bender.yml ====
package:
  name: cp_bond

sources:
  # design sources in compile order
  - files:
      - verilog/cp_bond_pkg.sv
      - verilog/cp_comp_cntr.sv
      - verilog/cp_tap_chain.sv
      - verilog/cp_bond_ctrl.sv
      - verilog/cp_bond_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/cp_bond_sva.sv
      - sim/cp_bond_tb.sv
